// ==== bench/ex_unit_tb.sv ====
// execute stage testbench with clock, reset, xorshift stimulus,
// reference model, response and handshake checks and a cycle limit
module ex_unit_tb;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 400;
    localparam int NUM_DIRECTED = 4;
    localparam int MAX_CYCLES   = (NUM_OPS + NUM_DIRECTED) * 40 + RESET_CYCLES;

    logic            clk;
    logic            arst_n_i;
    logic            req_i;
    ex_pkg::ex_req_t req_pkt_i;
    logic            ack_o;
    ex_pkg::ex_rsp_t rsp_o;

    logic [31:0] rng_state;
    int          cycle_cnt = 0;

    ex_unit dut_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .req_pkt_i (req_pkt_i),
        .ack_o     (ack_o),
        .rsp_o     (rsp_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the unit did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // corner values come up often
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 32'h0;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            default: return next_rand();
        endcase
    endfunction

    function automatic ex_pkg::ex_req_t random_req();
        ex_pkg::ex_req_t p;
        logic [31:0] r;
        logic [31:0] inst;
        r    = next_rand();
        inst = next_rand();
        if (r[3:0] < 4'd6) begin
            inst[6:0] = ex_pkg::OPC_TYPE_I;
            if (r[5:4] != 2'd0)     // otherwise funct7 stays random
                inst[31:25] = r[6] ? ex_pkg::F7_ALT : ex_pkg::F7_BASE;
        end else if (r[3:0] < 4'd10) begin
            inst[6:0] = ex_pkg::OPC_TYPE_R_M;
            if (r[5:4] != 2'd0)
                inst[31:25] = r[6] ? ex_pkg::F7_ALT : ex_pkg::F7_BASE;
        end else if (r[3:0] < 4'd13) begin
            inst[6:0] = ex_pkg::OPC_TYPE_B;
        end else if (r[3:0] < 4'd15) begin
            inst[6:0]   = ex_pkg::OPC_TYPE_R_M;
            inst[31:25] = ex_pkg::F7_MULDIV;   // multiply codes come out illegal
        end
        p.inst     = inst;
        p.pc       = next_rand() & 32'hffff_fffc;
        p.rs1_data = pick_operand();
        p.rs2_data = pick_operand();
        return p;
    endfunction

    function automatic ex_pkg::ex_req_t div_req(input logic [2:0] f3, input logic [31:0] a,
                                                input logic [31:0] b);
        ex_pkg::ex_req_t p;
        p.inst     = {ex_pkg::F7_MULDIV, 5'd2, 5'd1, f3, 5'd7, ex_pkg::OPC_TYPE_R_M};
        p.pc       = 32'h0000_1000;
        p.rs1_data = a;
        p.rs2_data = b;
        return p;
    endfunction

    function automatic logic is_divide(input logic [31:0] inst);
        return inst[6:0] == ex_pkg::OPC_TYPE_R_M && inst[31:25] == ex_pkg::F7_MULDIV
               && inst[14];
    endfunction

    // expected result packet under RV32IM semantics of the kept instructions
    function automatic ex_pkg::ex_rsp_t model_rsp(input ex_pkg::ex_req_t p);
        ex_pkg::ex_rsp_t rsp;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_b;
        logic [31:0] sra;
        logic [31:0] res;
        logic        ovf;
        logic        legal;
        logic        taken;
        rsp   = '0;
        opc   = p.inst[6:0];
        f3    = p.inst[14:12];
        f7    = p.inst[31:25];
        a     = p.rs1_data;
        b     = p.rs2_data;
        imm_b = {{20{p.inst[31]}}, p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
        res   = '0;
        legal = 1'b0;
        taken = 1'b0;
        ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (opc == ex_pkg::OPC_TYPE_I ||
            (opc == ex_pkg::OPC_TYPE_R_M && f7 != ex_pkg::F7_MULDIV)) begin
            if (opc == ex_pkg::OPC_TYPE_I) begin
                b     = {{20{p.inst[31]}}, p.inst[31:20]};
                legal = (f3 == 3'b001) ? (f7 == ex_pkg::F7_BASE) :
                        (f3 == 3'b101) ? (f7 == ex_pkg::F7_BASE || f7 == ex_pkg::F7_ALT) : 1'b1;
            end else begin
                legal = f7 == ex_pkg::F7_BASE ||
                        (f7 == ex_pkg::F7_ALT && (f3 == 3'b000 || f3 == 3'b101));
            end
            sra = $signed(a) >>> b[4:0];
            case (f3)
                3'b000:  res = (opc == ex_pkg::OPC_TYPE_R_M && f7 == ex_pkg::F7_ALT) ?
                               a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                3'b011:  res = {31'b0, a < b};
                3'b100:  res = a ^ b;
                3'b101:  res = (f7 == ex_pkg::F7_ALT) ? sra : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end else if (opc == ex_pkg::OPC_TYPE_R_M) begin
            legal = f3[2];
            if (f3 == 3'b100) begin
                if (b == '0)
                    res = '1;
                else if (ovf)
                    res = a;
                else
                    res = $signed(a) / $signed(b);
            end else if (f3 == 3'b101) begin
                res = (b == '0) ? '1 : a / b;
            end else if (f3 == 3'b110) begin
                if (b == '0)
                    res = a;
                else if (ovf)
                    res = '0;
                else
                    res = $signed(a) % $signed(b);
            end else begin
                res = (b == '0) ? a : a % b;
            end
        end else if (opc == ex_pkg::OPC_TYPE_B) begin
            legal = 1'b1;
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                3'b111:  taken = a >= b;
                default: legal = 1'b0;
            endcase
        end
        if (legal && opc == ex_pkg::OPC_TYPE_B) begin
            rsp.jump_flag = taken;
            rsp.jump_addr = taken ? p.pc + imm_b : '0;
        end else if (legal) begin
            rsp.reg_we    = 1'b1;
            rsp.reg_waddr = p.inst[11:7];
            rsp.reg_wdata = res;
        end
        return rsp;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("error %s: got %h expected %h", name, got, want);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_rsp(input ex_pkg::ex_rsp_t want);
        check("rsp_o.reg_we", 32'(rsp_o.reg_we), 32'(want.reg_we));
        check("rsp_o.reg_waddr", 32'(rsp_o.reg_waddr), 32'(want.reg_waddr));
        check("rsp_o.reg_wdata", rsp_o.reg_wdata, want.reg_wdata);
        check("rsp_o.jump_flag", 32'(rsp_o.jump_flag), 32'(want.jump_flag));
        check("rsp_o.jump_addr", rsp_o.jump_addr, want.jump_addr);
    endtask

    // one full four-phase transfer entered 1 unit after a rising edge
    task automatic run_op(input ex_pkg::ex_req_t p);
        ex_pkg::ex_rsp_t want;
        int lat;
        int hold;
        want      = model_rsp(p);
        req_pkt_i = p;
        req_i     = 1'b1;
        lat       = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!ack_o);
        if (!is_divide(p.inst))
            check("ack_o latency", 32'(lat), 32'd2);   // capture edge, then ack edge
        check_rsp(want);
        hold = next_rand() % 4;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check("ack_o", 32'(ack_o), 32'd1);
            check_rsp(want);
        end
        req_i     = 1'b0;
        req_pkt_i = random_req();   // packet is don't care now
        @(posedge clk);
        #1;
        check("ack_o", 32'(ack_o), 32'd0);
    endtask

    initial begin
        rng_state = 32'hc395bd6c;
        arst_n_i  = 1'b0;
        req_i     = 1'b0;
        req_pkt_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check("ack_o", 32'(ack_o), 32'd0);
        check_rsp('0);
        // divide corner cases
        run_op(div_req(ex_pkg::F3_DIV, 32'h8000_0000, 32'hffff_ffff));
        run_op(div_req(ex_pkg::F3_REM, 32'h8000_0000, 32'hffff_ffff));
        run_op(div_req(ex_pkg::F3_DIV, 32'h1234_5678, 32'h0));
        run_op(div_req(ex_pkg::F3_REMU, 32'hdead_beef, 32'h0));
        repeat (NUM_OPS) run_op(random_req());
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== ex_unit.f ====
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_div.sv
rtl/ex_ctrl.sv
rtl/ex_unit.sv
bench/ex_unit_tb.sv

// ==== rtl/ex_alu.sv ====
// integer ALU, branch condition and branch target
module ex_alu (
    input  ex_pkg::ex_op_t          op_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);

    logic [ex_pkg::XLEN-1:0]    op_b;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic lt_s;
    logic lt_u;
    logic eq;
    logic cond;

    assign op_b  = op_i.use_imm ? op_i.imm : rs2_i;
    assign shamt = op_b[ex_pkg::SHAMT_W-1:0];   // shamt field for immediate shifts

    // branches compare rs1 with rs2 since use_imm is clear for them
    assign lt_s = $signed(rs1_i) < $signed(op_b);
    assign lt_u = rs1_i < op_b;
    assign eq   = (rs1_i == op_b);

    always_comb begin
        case (op_i.alu_op)
            ex_pkg::ALU_ADD:  result_o = rs1_i + op_b;
            ex_pkg::ALU_SUB:  result_o = rs1_i - op_b;
            ex_pkg::ALU_SLL:  result_o = rs1_i << shamt;
            ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::ALU_XOR:  result_o = rs1_i ^ op_b;
            ex_pkg::ALU_SRL:  result_o = rs1_i >> shamt;
            ex_pkg::ALU_SRA:  result_o = $signed(rs1_i) >>> shamt;  // sign fill
            ex_pkg::ALU_OR:   result_o = rs1_i | op_b;
            ex_pkg::ALU_AND:  result_o = rs1_i & op_b;
            default:          result_o = '0;
        endcase
    end

    always_comb begin
        case (op_i.br_op)
            ex_pkg::BR_EQ:  cond = eq;
            ex_pkg::BR_NE:  cond = !eq;
            ex_pkg::BR_LT:  cond = lt_s;
            ex_pkg::BR_GE:  cond = !lt_s;
            ex_pkg::BR_LTU: cond = lt_u;
            ex_pkg::BR_GEU: cond = !lt_u;
            default:        cond = 1'b0;
        endcase
    end

    assign taken_o  = (op_i.kind == ex_pkg::KIND_BRANCH) && cond;
    assign target_o = pc_i + op_i.imm;

endmodule

// ==== rtl/ex_ctrl.sv ====
// req/ack handshake FSM, request latch and result register
module ex_ctrl (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    req_i,
    input  ex_pkg::ex_req_t         req_pkt_i,
    output logic                    ack_o,
    output ex_pkg::ex_rsp_t         rsp_o,
    output ex_pkg::ex_req_t         pkt_o,
    input  ex_pkg::ex_op_t          op_i,
    input  logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  logic                    taken_i,
    input  logic [ex_pkg::XLEN-1:0] target_i,
    output logic                    div_start_o,
    input  logic                    div_done_i,
    input  logic [ex_pkg::XLEN-1:0] div_result_i
);

    typedef enum logic [1:0] {IDLE, EXEC, DIV_WAIT, ACK} ctrl_state_e;

    ctrl_state_e     state;
    ex_pkg::ex_rsp_t exec_rsp;

    // single cycle result from the decoded op
    always_comb begin
        exec_rsp = '0;
        case (op_i.kind)
            ex_pkg::KIND_ALU: begin
                exec_rsp.reg_we    = 1'b1;
                exec_rsp.reg_waddr = op_i.rd;
                exec_rsp.reg_wdata = alu_result_i;
            end
            ex_pkg::KIND_BRANCH: begin
                exec_rsp.jump_flag = taken_i;
                exec_rsp.jump_addr = taken_i ? target_i : '0;
            end
            default: exec_rsp = '0;
        endcase
    end

    assign div_start_o = (state == EXEC) && (op_i.kind == ex_pkg::KIND_DIV);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
            ack_o <= 1'b0;
            rsp_o <= '0;
        end else begin
            case (state)
                IDLE: if (req_i) state <= EXEC;
                EXEC: begin
                    if (op_i.kind == ex_pkg::KIND_DIV) begin
                        state <= DIV_WAIT;
                    end else begin
                        rsp_o <= exec_rsp;
                        ack_o <= 1'b1;
                        state <= ACK;
                    end
                end
                DIV_WAIT: begin
                    if (div_done_i) begin
                        rsp_o           <= '0;
                        rsp_o.reg_we    <= 1'b1;
                        rsp_o.reg_waddr <= op_i.rd;
                        rsp_o.reg_wdata <= div_result_i;
                        ack_o           <= 1'b1;
                        state           <= ACK;
                    end
                end
                ACK: begin
                    if (!req_i) begin   // hold until requester lets go
                        ack_o <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) pkt_o <= req_pkt_i;
    end

endmodule

// ==== rtl/ex_decode.sv ====
// instruction decode into kind, sub-operation, immediate and rd
module ex_decode (
    input  logic [ex_pkg::XLEN-1:0] inst_i,
    output ex_pkg::ex_op_t          op_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [ex_pkg::XLEN-1:0] i_imm;
    logic [ex_pkg::XLEN-1:0] b_imm;
    ex_pkg::ex_op_t op;
    logic legal;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign i_imm  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign b_imm  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                     inst_i[11:8], 1'b0};

    always_comb begin
        op       = '0;
        op.rd    = inst_i[11:7];
        legal    = 1'b1;
        case (opcode)
            ex_pkg::OPC_TYPE_I: begin
                op.kind    = ex_pkg::KIND_ALU;
                op.use_imm = 1'b1;
                op.imm     = i_imm;
                case (funct3)
                    ex_pkg::F3_ADDI:  op.alu_op = ex_pkg::ALU_ADD;
                    ex_pkg::F3_SLTI:  op.alu_op = ex_pkg::ALU_SLT;
                    ex_pkg::F3_SLTIU: op.alu_op = ex_pkg::ALU_SLTU;
                    ex_pkg::F3_XORI:  op.alu_op = ex_pkg::ALU_XOR;
                    ex_pkg::F3_ORI:   op.alu_op = ex_pkg::ALU_OR;
                    ex_pkg::F3_ANDI:  op.alu_op = ex_pkg::ALU_AND;
                    ex_pkg::F3_SLLI: begin
                        op.alu_op = ex_pkg::ALU_SLL;
                        legal     = (funct7 == ex_pkg::F7_BASE);
                    end
                    ex_pkg::F3_SRI: begin
                        op.alu_op = inst_i[30] ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                        legal     = (funct7 == ex_pkg::F7_BASE) || (funct7 == ex_pkg::F7_ALT);
                    end
                    default: legal = 1'b0;
                endcase
            end
            ex_pkg::OPC_TYPE_R_M: begin
                if (funct7 == ex_pkg::F7_MULDIV) begin
                    op.kind = ex_pkg::KIND_DIV;
                    case (funct3)
                        ex_pkg::F3_DIV:  op.div_op = ex_pkg::DIV_DIV;
                        ex_pkg::F3_DIVU: op.div_op = ex_pkg::DIV_DIVU;
                        ex_pkg::F3_REM:  op.div_op = ex_pkg::DIV_REM;
                        ex_pkg::F3_REMU: op.div_op = ex_pkg::DIV_REMU;
                        default: legal = 1'b0;     // multiply not supported
                    endcase
                end else begin
                    op.kind = ex_pkg::KIND_ALU;
                    // alt encoding only for sub and sra
                    legal = (funct7 == ex_pkg::F7_BASE) ||
                            ((funct7 == ex_pkg::F7_ALT) &&
                             (funct3 == ex_pkg::F3_ADD_SUB || funct3 == ex_pkg::F3_SR));
                    case (funct3)
                        ex_pkg::F3_ADD_SUB: op.alu_op = inst_i[30] ? ex_pkg::ALU_SUB
                                                                   : ex_pkg::ALU_ADD;
                        ex_pkg::F3_SLL:  op.alu_op = ex_pkg::ALU_SLL;
                        ex_pkg::F3_SLT:  op.alu_op = ex_pkg::ALU_SLT;
                        ex_pkg::F3_SLTU: op.alu_op = ex_pkg::ALU_SLTU;
                        ex_pkg::F3_XOR:  op.alu_op = ex_pkg::ALU_XOR;
                        ex_pkg::F3_SR:   op.alu_op = inst_i[30] ? ex_pkg::ALU_SRA
                                                                : ex_pkg::ALU_SRL;
                        ex_pkg::F3_OR:   op.alu_op = ex_pkg::ALU_OR;
                        ex_pkg::F3_AND:  op.alu_op = ex_pkg::ALU_AND;
                        default: legal = 1'b0;
                    endcase
                end
            end
            ex_pkg::OPC_TYPE_B: begin
                op.kind = ex_pkg::KIND_BRANCH;
                op.imm  = b_imm;
                case (funct3)
                    ex_pkg::F3_BEQ:  op.br_op = ex_pkg::BR_EQ;
                    ex_pkg::F3_BNE:  op.br_op = ex_pkg::BR_NE;
                    ex_pkg::F3_BLT:  op.br_op = ex_pkg::BR_LT;
                    ex_pkg::F3_BGE:  op.br_op = ex_pkg::BR_GE;
                    ex_pkg::F3_BLTU: op.br_op = ex_pkg::BR_LTU;
                    ex_pkg::F3_BGEU: op.br_op = ex_pkg::BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // anything unrecognised becomes an empty op
    assign op_o = legal ? op : '0;

endmodule

// ==== rtl/ex_div.sv ====
// iterative restoring divider, signed and unsigned, quotient or remainder
// done comes 34 cycles after start with load, 32 bit steps and sign fix
module ex_div (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    start_i,
    input  ex_pkg::div_op_e         div_op_i,
    input  logic [ex_pkg::XLEN-1:0] dividend_i,
    input  logic [ex_pkg::XLEN-1:0] divisor_i,
    output logic                    done_o,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    typedef enum logic [1:0] {D_IDLE, D_CALC, D_FIX} div_state_e;

    div_state_e state;
    logic [$clog2(ex_pkg::XLEN)-1:0] cnt;
    logic [ex_pkg::XLEN-1:0] quo;
    logic [ex_pkg::XLEN-1:0] rem;
    logic [ex_pkg::XLEN-1:0] dvs;
    logic [ex_pkg::XLEN-1:0] a_mag;
    logic [ex_pkg::XLEN-1:0] b_mag;
    logic [ex_pkg::XLEN:0]   rem_shift;
    logic [ex_pkg::XLEN:0]   diff;
    logic is_signed;
    logic neg_q;
    logic neg_r;
    logic want_rem;

    assign is_signed = (div_op_i == ex_pkg::DIV_DIV) || (div_op_i == ex_pkg::DIV_REM);
    assign a_mag = (is_signed && dividend_i[ex_pkg::XLEN-1]) ? -dividend_i : dividend_i;
    assign b_mag = (is_signed && divisor_i[ex_pkg::XLEN-1]) ? -divisor_i : divisor_i;

    assign rem_shift = {rem, quo[ex_pkg::XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs};  // msb set means no subtract

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state  <= D_IDLE;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start_i) begin
                        state <= D_CALC;
                        cnt   <= '0;
                    end
                end
                D_CALC: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt) state <= D_FIX;
                end
                D_FIX: begin
                    state  <= D_IDLE;
                    done_o <= 1'b1;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && start_i) begin
            quo      <= a_mag;
            rem      <= '0;
            dvs      <= b_mag;
            // divide by zero keeps an all-ones quotient
            neg_q    <= is_signed && (dividend_i[ex_pkg::XLEN-1] ^ divisor_i[ex_pkg::XLEN-1])
                        && (divisor_i != '0);
            neg_r    <= is_signed && dividend_i[ex_pkg::XLEN-1];
            want_rem <= (div_op_i == ex_pkg::DIV_REM) || (div_op_i == ex_pkg::DIV_REMU);
        end else if (state == D_CALC) begin
            if (!diff[ex_pkg::XLEN]) begin
                rem <= diff[ex_pkg::XLEN-1:0];
                quo <= {quo[ex_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_shift[ex_pkg::XLEN-1:0];
                quo <= {quo[ex_pkg::XLEN-2:0], 1'b0};
            end
        end else if (state == D_FIX) begin
            if (want_rem) result_o <= neg_r ? -rem : rem;
            else          result_o <= neg_q ? -quo : quo;
        end
    end

endmodule

// ==== rtl/ex_pkg.sv ====
// widths, opcode and funct codes of the execute stage
// operation enums, request/result packets and decoded operation
package ex_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int SHAMT_W = 5;

    localparam logic [6:0] OPC_TYPE_I   = 7'b0010011;
    localparam logic [6:0] OPC_TYPE_R_M = 7'b0110011;
    localparam logic [6:0] OPC_TYPE_B   = 7'b1100011;

    // I type
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SRI   = 3'b101;   // srli and srai
    // R type
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    // divide under funct7 muldiv
    localparam logic [2:0] F3_DIV  = 3'b100;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REM  = 3'b110;
    localparam logic [2:0] F3_REMU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

    typedef enum logic [1:0] {KIND_NONE, KIND_ALU, KIND_BRANCH, KIND_DIV} op_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } ex_req_t;

    typedef struct packed {
        logic              reg_we;
        logic [REG_AW-1:0] reg_waddr;
        logic [XLEN-1:0]   reg_wdata;
        logic              jump_flag;
        logic [XLEN-1:0]   jump_addr;
    } ex_rsp_t;

    typedef struct packed {
        op_kind_e          kind;
        alu_op_e           alu_op;
        br_op_e            br_op;
        div_op_e           div_op;
        logic              use_imm;
        logic [XLEN-1:0]   imm;     // sign-extended I or B immediate
        logic [REG_AW-1:0] rd;
    } ex_op_t;

endpackage

// ==== rtl/ex_unit.sv ====
// execute stage top: controller, decoder, ALU and divider
module ex_unit (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            req_i,
    input  ex_pkg::ex_req_t req_pkt_i,
    output logic            ack_o,
    output ex_pkg::ex_rsp_t rsp_o
);

    ex_pkg::ex_req_t         pkt;
    ex_pkg::ex_op_t          op;
    logic [ex_pkg::XLEN-1:0] alu_result;
    logic                    taken;
    logic [ex_pkg::XLEN-1:0] target;
    logic                    div_start;
    logic                    div_done;
    logic [ex_pkg::XLEN-1:0] div_result;

    ex_ctrl u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .req_pkt_i    (req_pkt_i),
        .ack_o        (ack_o),
        .rsp_o        (rsp_o),
        .pkt_o        (pkt),
        .op_i         (op),
        .alu_result_i (alu_result),
        .taken_i      (taken),
        .target_i     (target),
        .div_start_o  (div_start),
        .div_done_i   (div_done),
        .div_result_i (div_result)
    );

    ex_decode u_decode (
        .inst_i (pkt.inst),
        .op_o   (op)
    );

    ex_alu u_alu (
        .op_i     (op),
        .pc_i     (pkt.pc),
        .rs1_i    (pkt.rs1_data),
        .rs2_i    (pkt.rs2_data),
        .result_o (alu_result),
        .taken_o  (taken),
        .target_o (target)
    );

    ex_div u_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .div_op_i   (op.div_op),
        .dividend_i (pkt.rs1_data),
        .divisor_i  (pkt.rs2_data),
        .done_o     (div_done),
        .result_o   (div_result)
    );

endmodule

// ==== run.sh ====
#!/bin/bash
# build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --top-module ex_unit_tb -f ex_unit.f -o ex_unit_sim \
    && ./obj_dir/ex_unit_sim | tee /dev/stderr | grep -q "Simulation passed" \
    || { echo "execute stage run did not pass"; exit 1; }
